// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_soc_top
FILELIST  := soc_top.f
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: hdl/axil_decoder.sv
`timescale 1ns/1ns

module axil_decoder
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  axi_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axi_data_t  wdata,
    input  axi_strb_t  wstrb,
    input  logic       wvalid,
    output logic       wready,
    output axi_resp_t  bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axi_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output axi_data_t  rdata,
    output axi_resp_t  rresp,
    output logic       rvalid,
    input  logic       rready,

    output word_addr_t word_addr,
    output axi_data_t  wdata_s,
    output axi_strb_t  wstrb_s,
    output logic       ram_wr,
    output logic       ram_rd,
    output logic       rom_rd,
    output logic       uart_wr,
    output logic       uart_rd,
    input  axi_data_t  ram_rdata,
    input  axi_data_t  rom_rdata,
    input  axi_data_t  uart_rdata
);
    region_t aw_region;
    region_t ar_region;
    region_t rd_region;
    logic    wr_hs;
    logic    ar_hs;
    logic    aw_go;
    logic    ar_go;
    logic    rd_wait;
    logic    rd_busy;

    function automatic region_t decode_region(input axi_addr_t addr);
        case (addr[31:28])
            ROM_BASE:    return REGION_ROM;
            RAM_BASE:    return REGION_RAM;
            PERIPH_BASE: return REGION_PERIPH;
            default:     return REGION_NONE;
        endcase
    endfunction

    assign aw_region = decode_region(awaddr);
    assign ar_region = decode_region(araddr);
    assign wr_hs     = awvalid && awready && wvalid && wready;
    assign ar_hs     = arvalid && arready;
    assign rd_busy   = rd_wait || rvalid;
    assign ar_go     = arvalid && !arready && !rd_busy;
    // a read accept wins the cycle so the two channels never share the strobe bus.
    assign aw_go     = awvalid && wvalid && !awready && !bvalid && !ar_go;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            bresp     <= RESP_OKAY;
            arready   <= 1'b0;
            rd_wait   <= 1'b0;
            rvalid    <= 1'b0;
            rresp     <= RESP_OKAY;
            rd_region <= REGION_NONE;
        end else begin
            awready <= aw_go;
            wready  <= aw_go;
            arready <= ar_go;
            rd_wait <= ar_hs;                                // slave strobe is out this cycle.
            if (wr_hs) begin
                bvalid <= 1'b1;
                case (aw_region)
                    REGION_NONE: bresp <= RESP_DECERR;
                    REGION_ROM:  bresp <= RESP_SLVERR;
                    default:     bresp <= RESP_OKAY;
                endcase
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (ar_hs) begin
                rd_region <= ar_region;
                rresp     <= (ar_region == REGION_NONE) ? RESP_DECERR : RESP_OKAY;
            end
            if (rd_wait) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_wr  <= 1'b0;
            uart_wr <= 1'b0;
            ram_rd  <= 1'b0;
            rom_rd  <= 1'b0;
            uart_rd <= 1'b0;
        end else begin
            ram_wr  <= wr_hs && (aw_region == REGION_RAM);
            uart_wr <= wr_hs && (aw_region == REGION_PERIPH);
            ram_rd  <= ar_hs && (ar_region == REGION_RAM);
            rom_rd  <= ar_hs && (ar_region == REGION_ROM);
            uart_rd <= ar_hs && (ar_region == REGION_PERIPH);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            word_addr <= awaddr[2 +: $bits(word_addr_t)];
            wdata_s   <= wdata;
            wstrb_s   <= wstrb;
        end else if (ar_hs) begin
            word_addr <= araddr[2 +: $bits(word_addr_t)];
        end
    end

    // slave data registers only move on their own read strobe, so this holds until rready.
    always_comb begin
        case (rd_region)
            REGION_ROM:    rdata = rom_rdata;
            REGION_RAM:    rdata = ram_rdata;
            REGION_PERIPH: rdata = uart_rdata;
            default:       rdata = '0;
        endcase
    end

    strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_wr, ram_rd, rom_rd, uart_wr, uart_rd}));

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// File: hdl/axil_ram.sv
`timescale 1ns/1ns

module axil_ram
    import soc_pkg::*;
(
    input  logic       clk,
    input  word_addr_t word_addr,
    input  axi_data_t  wdata,
    input  axi_strb_t  wstrb,
    input  logic       wr,
    input  logic       rd,
    output axi_data_t  rdata
);
    axi_data_t mem [RAM_WORDS];

    always_ff @(posedge clk) begin
        if (wr) begin
            for (int i = 0; i < $bits(axi_strb_t); i++) begin
                if (wstrb[i]) begin
                    mem[word_addr][8*i +: 8] <= wdata[8*i +: 8];   // one lane per strobe bit.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= mem[word_addr];
        end
    end

    // the decoder must never issue a read and a write to the RAM in one cycle.
    wr_rd_exclusive: assert property (@(posedge clk) !(wr && rd));

endmodule

// File: hdl/boot_rom.sv
`timescale 1ns/1ns

module boot_rom
    import soc_pkg::*;
(
    input  logic       clk,
    input  word_addr_t word_addr,
    input  logic       rd,
    output axi_data_t  rdata
);
    axi_data_t mem [ROM_WORDS];

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    // same one-cycle latency as the RAM, so the decoder times both alike.
    always_ff @(posedge clk) begin
        if (rd) begin
            rdata <= mem[word_addr[$clog2(ROM_WORDS)-1:0]];   // upper bits alias.
        end
    end

endmodule

// File: hdl/bootldr.hex
// boot ROM image, one 32-bit word per line in hex, word 0 first.
00000093
00000113
100001b7
00018193
30000237
04800293
00522023
06900293
00522023
0001a303
00130313
0061a023
00418193
fe0008e3
00000013
0000006f

// File: hdl/soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [12:0] word_addr_t;                 // covers the 32 KiB RAM.

    typedef enum logic [1:0] {
        REGION_ROM,
        REGION_RAM,
        REGION_PERIPH,
        REGION_NONE
    } region_t;

    localparam logic [3:0] ROM_BASE    = 4'h0;
    localparam logic [3:0] RAM_BASE    = 4'h1;
    localparam logic [3:0] PERIPH_BASE = 4'h3;        // 0x2 is left unmapped.

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;
    localparam axi_resp_t RESP_DECERR = 2'b11;

    localparam int    RAM_WORDS = 8192;
    localparam int    ROM_WORDS = 16;
    localparam string ROM_FILE  = "hdl/bootldr.hex";

    localparam int UART_CLKS_PER_BIT = 8;             // short bit time for simulation.
    typedef logic [$clog2(UART_CLKS_PER_BIT)-1:0] uart_cnt_t;
    localparam uart_cnt_t UART_BIT_LAST  = uart_cnt_t'(UART_CLKS_PER_BIT - 1);
    localparam uart_cnt_t UART_HALF_LAST = uart_cnt_t'(UART_CLKS_PER_BIT / 2 - 1);

    localparam word_addr_t UART_TX_REG     = 13'd0;
    localparam word_addr_t UART_STATUS_REG = 13'd1;
    localparam word_addr_t UART_RX_REG     = 13'd2;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} uart_state_t;

endpackage

// File: hdl/soc_top.sv
`timescale 1ns/1ns

module soc_top
    import soc_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  axi_strb_t wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axi_resp_t bresp,
    output logic      bvalid,
    input  logic      bready,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output axi_resp_t rresp,
    output logic      rvalid,
    input  logic      rready,

    output logic      uart_tx,
    input  logic      uart_rx
);
    word_addr_t bus_word_addr;
    axi_data_t  bus_wdata;
    axi_strb_t  bus_wstrb;
    logic       ram_wr;
    logic       ram_rd;
    logic       rom_rd;
    logic       uart_wr;
    logic       uart_rd;
    axi_data_t  ram_rdata;
    axi_data_t  rom_rdata;
    axi_data_t  uart_rdata;

    axil_decoder decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .word_addr  (bus_word_addr),
        .wdata_s    (bus_wdata),
        .wstrb_s    (bus_wstrb),
        .ram_wr     (ram_wr),
        .ram_rd     (ram_rd),
        .rom_rd     (rom_rd),
        .uart_wr    (uart_wr),
        .uart_rd    (uart_rd),
        .ram_rdata  (ram_rdata),
        .rom_rdata  (rom_rdata),
        .uart_rdata (uart_rdata)
    );

    axil_ram ram (
        .clk       (clk),
        .word_addr (bus_word_addr),
        .wdata     (bus_wdata),
        .wstrb     (bus_wstrb),
        .wr        (ram_wr),
        .rd        (ram_rd),
        .rdata     (ram_rdata)
    );

    boot_rom rom (
        .clk       (clk),
        .word_addr (bus_word_addr),
        .rd        (rom_rd),
        .rdata     (rom_rdata)
    );

    uart_periph uart (
        .clk       (clk),
        .rst_n     (rst_n),
        .word_addr (bus_word_addr),
        .wdata     (bus_wdata),
        .wr        (uart_wr),
        .rd        (uart_rd),
        .rdata     (uart_rdata),
        .uart_tx   (uart_tx),
        .uart_rx   (uart_rx)
    );

endmodule

// File: hdl/uart_periph.sv
`timescale 1ns/1ns

module uart_periph
    import soc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  word_addr_t word_addr,
    input  axi_data_t  wdata,
    input  logic       wr,
    input  logic       rd,
    output axi_data_t  rdata,
    output logic       uart_tx,
    input  logic       uart_rx
);
    uart_state_t tx_state;
    uart_cnt_t   tx_clk_cnt;
    logic [2:0]  tx_bit_cnt;
    logic [7:0]  tx_shift;
    logic        tx_start;
    logic        tx_busy;
    logic        tx_bit_end;

    uart_state_t rx_state;
    uart_cnt_t   rx_clk_cnt;
    logic [2:0]  rx_bit_cnt;
    logic [7:0]  rx_shift;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic [1:0]  rx_sync;
    logic        rx_bit_end;

    assign tx_start   = wr && (word_addr == UART_TX_REG);
    assign tx_busy    = (tx_state != IDLE);
    assign tx_bit_end = (tx_clk_cnt == UART_BIT_LAST);
    assign rx_bit_end = (rx_clk_cnt == UART_BIT_LAST);
    assign uart_tx    = (tx_state == START) ? 1'b0 :
                        (tx_state == DATA)  ? tx_shift[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_state   <= IDLE;
            tx_clk_cnt <= '0;
            tx_bit_cnt <= '0;
        end else begin
            if (tx_state == IDLE || tx_bit_end) begin
                tx_clk_cnt <= '0;
            end else begin
                tx_clk_cnt <= tx_clk_cnt + 1'b1;
            end
            case (tx_state)
                IDLE:  if (tx_start) tx_state <= START;   // a write while busy is dropped.
                START: if (tx_bit_end) tx_state <= DATA;
                DATA: begin
                    if (tx_bit_end) begin
                        tx_bit_cnt <= tx_bit_cnt + 1'b1;
                        if (tx_bit_cnt == 3'd7) tx_state <= STOP;
                    end
                end
                STOP:  if (tx_bit_end) tx_state <= IDLE;
                default: tx_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (tx_state == IDLE && tx_start) begin
            tx_shift <= wdata[7:0];
        end else if (tx_state == DATA && tx_bit_end) begin
            tx_shift <= tx_shift >> 1;                    // lsb goes out first.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync    <= 2'b11;
            rx_state   <= IDLE;
            rx_clk_cnt <= '0;
            rx_bit_cnt <= '0;
            rx_valid   <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
            if (rd && word_addr == UART_RX_REG) rx_valid <= 1'b0;
            case (rx_state)
                IDLE: begin
                    rx_clk_cnt <= '0;
                    if (!rx_sync[1]) rx_state <= START;
                end
                START: begin
                    if (rx_clk_cnt == UART_HALF_LAST) begin   // mid start bit.
                        rx_clk_cnt <= '0;
                        rx_state   <= rx_sync[1] ? IDLE : DATA;
                    end else begin
                        rx_clk_cnt <= rx_clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    rx_clk_cnt <= rx_bit_end ? '0 : rx_clk_cnt + 1'b1;
                    if (rx_bit_end) begin
                        rx_bit_cnt <= rx_bit_cnt + 1'b1;
                        if (rx_bit_cnt == 3'd7) rx_state <= STOP;
                    end
                end
                STOP: begin
                    rx_clk_cnt <= rx_bit_end ? '0 : rx_clk_cnt + 1'b1;
                    if (rx_bit_end) begin
                        rx_state <= IDLE;
                        if (rx_sync[1]) rx_valid <= 1'b1;     // framing error drops the byte.
                    end
                end
                default: rx_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == DATA && rx_bit_end) begin
            rx_shift <= {rx_sync[1], rx_shift[7:1]};
        end
        if (rx_state == STOP && rx_bit_end && rx_sync[1]) begin
            rx_data <= rx_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            case (word_addr)
                UART_STATUS_REG: rdata <= {30'd0, rx_valid, tx_busy};
                UART_RX_REG:     rdata <= {24'd0, rx_data};
                default:         rdata <= '0;
            endcase
        end
    end

    tx_start_only: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(uart_tx) && !$past(tx_busy) |-> $past(wr && word_addr == UART_TX_REG));

endmodule

// File: soc_top.f
hdl/soc_pkg.sv
hdl/axil_decoder.sv
hdl/axil_ram.sv
hdl/boot_rom.sv
hdl/uart_periph.sv
hdl/soc_top.sv
verification/tb_soc_top.sv

// File: verification/tb_soc_top.sv
`timescale 1ns/1ns

module tb_soc_top
    import soc_pkg::*;
();
    localparam int READ_LATENCY   = 2;
    localparam int RESET_CYCLES   = 5;
    localparam int OP_CYCLES      = 12;                // worst case for one op with a stall of 3.
    localparam int RAM_PAIRS      = 12;
    localparam int NUM_OPS        = 18 + 3 * RAM_PAIRS + 4 + 4 + 4 + 5;
    localparam int UART_WAIT      = 10 * UART_CLKS_PER_BIT + 4;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + NUM_OPS * OP_CYCLES + UART_WAIT);

    typedef struct {
        logic      is_read;
        axi_data_t got_data;
        axi_data_t exp_data;
        axi_resp_t got_resp;
        axi_resp_t exp_resp;
    } result_t;

    logic      clk = 1'b0;
    logic      rst_n;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    logic      uart_tx;
    logic      uart_rx;

    axi_data_t   rom_words [ROM_WORDS];
    axi_data_t   shadow_ram [RAM_WORDS];
    logic        exp_tx_busy = 1'b0;
    logic        exp_rx_valid = 1'b0;
    logic [7:0]  exp_rx_byte = 8'h00;
    logic [7:0]  exp_tx_byte = 8'h00;
    logic [31:0] lfsr_state = 32'h9457129e;
    result_t     results [$];
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          test_errors_start;
    string       test_name;

    soc_top uut (.*);

    assign uart_rx = uart_tx;                          // loopback through the receiver.

    always #2 clk = ~clk;

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            // taps 32, 22, 2, 1.
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int random_stall();
        return int'(random_bits(2));
    endfunction

    function automatic axi_addr_t uart_addr(input word_addr_t reg_word);
        return {PERIPH_BASE, 13'd0, reg_word, 2'b00};
    endfunction

    function automatic void expected_read(input axi_addr_t addr, output axi_data_t data,
                                          output axi_resp_t resp);
        data = '0;
        resp = RESP_OKAY;
        case (addr[31:28])
            ROM_BASE: data = rom_words[addr[5:2]];
            RAM_BASE: data = shadow_ram[addr[14:2]];
            PERIPH_BASE: begin
                if (addr[14:2] == UART_STATUS_REG) begin
                    data = {30'd0, exp_rx_valid, exp_tx_busy};
                end else if (addr[14:2] == UART_RX_REG) begin
                    data = {24'd0, exp_rx_byte};
                end
            end
            default: resp = RESP_DECERR;
        endcase
    endfunction

    function automatic axi_resp_t expected_write_resp(input axi_addr_t addr);
        case (addr[31:28])
            ROM_BASE, RAM_BASE, PERIPH_BASE: return (addr[31:28] == ROM_BASE) ? RESP_SLVERR
                                                                               : RESP_OKAY;
            default: return RESP_DECERR;
        endcase
    endfunction

    function automatic void shadow_write(input axi_addr_t addr, input axi_data_t data,
                                         input axi_strb_t strb);
        if (addr[31:28] == RAM_BASE) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) shadow_ram[addr[14:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    task automatic check_data(input axi_data_t got, input axi_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: read data %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_resp(input axi_resp_t got, input axi_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: response %0d, expected %0d", $time, got, exp);
        end
    endtask

    // starts and ends on a falling edge, like every master task.
    task automatic axil_write(input axi_addr_t addr, input axi_data_t data,
                              input axi_strb_t strb, input int stall);
        result_t res;
        res.is_read  = 1'b0;
        res.got_data = '0;
        res.exp_data = '0;
        res.exp_resp = expected_write_resp(addr);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        shadow_write(addr, data, strb);
        while (!bvalid) @(negedge clk);
        res.got_resp = bresp;
        repeat (stall) begin
            @(negedge clk);
            if (!bvalid || bresp !== res.got_resp) begin
                errors++;
                $display("ERROR at %0t ns: write response changed while bready was low", $time);
            end
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        results.push_back(res);
    endtask

    task automatic axil_read(input axi_addr_t addr, input int stall);
        result_t res;
        int      latency;
        res.is_read = 1'b1;
        expected_read(addr, res.exp_data, res.exp_resp);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (stall == 0);
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(negedge clk);                                // the handshake edge has passed.
        arvalid = 1'b0;
        latency = 1;
        while (!rvalid) begin
            @(negedge clk);
            latency++;
        end
        if (latency != READ_LATENCY) begin
            errors++;
            $display("ERROR at %0t ns: rvalid came %0d cycles after the AR handshake, expected %0d",
                     $time, latency, READ_LATENCY);
        end
        res.got_data = rdata;
        res.got_resp = rresp;
        repeat (stall) begin
            @(negedge clk);
            if (!rvalid || rdata !== res.got_data || rresp !== res.got_resp) begin
                errors++;
                $display("ERROR at %0t ns: read response changed while rready was low", $time);
            end
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        results.push_back(res);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors_start = errors;
    endtask

    task automatic finish_test();
        while (results.size() != 0) @(negedge clk);
        tests++;
        $display("test %0d %s: %s", tests, test_name,
                 (errors == test_errors_start) ? "ok" : "failed");
    endtask

    always @(posedge clk) begin
        result_t res;
        while (results.size() > 0) begin
            res = results.pop_front();
            if (res.is_read) check_data(res.got_data, res.exp_data);
            check_resp(res.got_resp, res.exp_resp);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // samples uart_tx in the middle of each bit time, apart from the receiver.
    initial begin
        logic [9:0] frame;
        @(posedge rst_n);
        checks++;
        if (uart_tx !== 1'b1) begin
            errors++;
            $display("ERROR at %0t ns: uart_tx is %b after reset, expected idle high",
                     $time, uart_tx);
        end
        forever begin
            @(negedge uart_tx);
            repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
            for (int i = 0; i < 10; i++) begin
                if (i != 0) repeat (UART_CLKS_PER_BIT) @(negedge clk);
                frame[i] = uart_tx;
            end
            checks++;
            if (frame !== {1'b1, exp_tx_byte, 1'b0}) begin
                errors++;
                $display("ERROR at %0t ns: uart_tx frame %b, expected %b", $time, frame,
                         {1'b1, exp_tx_byte, 1'b0});
            end
        end
    end

    initial begin
        axi_addr_t  addr;
        axi_addr_t  ram_addrs [$];
        logic [7:0] tx_byte;
        $readmemh(ROM_FILE, rom_words);
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("rom reads and write");
        for (int i = 0; i < ROM_WORDS; i++) axil_read(axi_addr_t'(i * 4), random_stall());
        axil_write(32'h0000_0008, random_bits(32), 4'hf, random_stall());
        axil_read(32'h0000_0008, random_stall());
        finish_test();

        start_test("ram byte strobes");
        for (int i = 0; i < RAM_PAIRS; i++) begin
            addr = {RAM_BASE, 13'd0, word_addr_t'(random_bits(13)), 2'b00};
            ram_addrs.push_back(addr);
            axil_write(addr, random_bits(32), 4'hf, random_stall());
            axil_write(addr, random_bits(32), axi_strb_t'(random_bits(4)), random_stall());
        end
        foreach (ram_addrs[i]) axil_read(ram_addrs[i], random_stall());
        finish_test();

        start_test("unmapped regions");
        axil_write(32'h2000_0010, random_bits(32), 4'hf, random_stall());
        axil_read(32'h2000_0010, random_stall());
        axil_write(32'h5000_0100, random_bits(32), 4'hf, random_stall());
        axil_read(32'h5000_0100, random_stall());
        finish_test();

        start_test("read latency");
        for (int i = 0; i < 4; i++) axil_read(ram_addrs[i], 0);
        finish_test();

        start_test("back-pressure");
        axil_write(ram_addrs[0], random_bits(32), 4'hf, 3);
        axil_read(ram_addrs[0], 3);
        axil_write(32'h0000_0004, random_bits(32), 4'hf, 3);
        axil_read(32'h5000_0000, 3);
        finish_test();

        start_test("uart loopback");
        tx_byte = 8'(random_bits(8));
        exp_tx_byte = tx_byte;
        axil_write(uart_addr(UART_TX_REG), {24'd0, tx_byte}, 4'h1, 0);
        exp_tx_busy = 1'b1;
        axil_read(uart_addr(UART_STATUS_REG), 0);
        repeat (UART_WAIT) @(negedge clk);
        exp_tx_busy  = 1'b0;
        exp_rx_valid = 1'b1;
        exp_rx_byte  = tx_byte;
        axil_read(uart_addr(UART_STATUS_REG), 0);
        axil_read(uart_addr(UART_RX_REG), 0);
        exp_rx_valid = 1'b0;                           // reading the byte clears rx_valid.
        axil_read(uart_addr(UART_STATUS_REG), 0);
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
